// ==== build.f ====
design/uart_reg_pkg.sv
design/su_proto_pkg.sv
design/byte_fifo.sv
design/uart_regs.sv
design/su_cmd_parser.sv
design/su_rsp_serializer.sv
design/uart_tx_arbiter.sv
design/apb_uart_top.sv
verif/apb_uart_assert.sv
verif/tb_apb_uart.sv

// ==== Bender.yml ====
package:
  name: apb_uart

dependencies: {}

sources:
  - design/uart_reg_pkg.sv
  - design/su_proto_pkg.sv
  - design/byte_fifo.sv
  - design/uart_regs.sv
  - design/su_cmd_parser.sv
  - design/su_rsp_serializer.sv
  - design/uart_tx_arbiter.sv
  - design/apb_uart_top.sv
  - target: test
    files:
      - verif/apb_uart_assert.sv
      - verif/tb_apb_uart.sv

// ==== verif/tb_apb_uart.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_apb_uart
   import uart_reg_pkg::*, su_proto_pkg::*;
();

   localparam int CLK_PERIOD   = 10;
   localparam int RESET_CYCLES = 8;
   // a few hundred cycles of tests plus wide margin
   localparam int TEST_CYCLE_BUDGET = 2000;
   localparam int WATCHDOG_NS       = TEST_CYCLE_BUDGET * CLK_PERIOD;
   localparam logic [31:0] SEED     = 32'hd66f_9f7c;
   localparam logic [31:0] RSP_MASK = 32'h5A5A_5A5A;   // remote master read pattern

   logic        CLK;
   logic        RSTN;
   apb_req_t    apb_req;
   logic [7:0]  prdata;
   logic        rx_valid;
   logic [7:0]  rx_data;
   logic        rx_credit;
   logic        tx_valid;
   logic [7:0]  tx_data;
   logic        tx_credit;
   logic        cmd_valid;
   su_cmd_t     cmd;
   logic        rsp_valid;
   logic [31:0] rsp_data;

   int          errors;
   int          checks;
   logic [31:0] rng_state;
   logic [7:0]  tx_seen[$];     // bytes the phy received
   logic [7:0]  tx_expect[$];
   su_cmd_t     cmd_seen[$];
   int          in_flight;
   int          owed;
   logic [2:0]  phy_pipe;
   bit          hold_credits;
   bit          phy_give;
   int          rx_credits;
   int          credit_count;
   int          rx_sent;
   logic        cmd_valid_d;
   logic [31:0] rd_addr;

   apb_uart_top u_dut (
      .CLK         (CLK),
      .RSTN        (RSTN),
      .apb_req_i   (apb_req),
      .prdata_o    (prdata),
      .rx_valid_i  (rx_valid),
      .rx_data_i   (rx_data),
      .rx_credit_o (rx_credit),
      .tx_valid_o  (tx_valid),
      .tx_data_o   (tx_data),
      .tx_credit_i (tx_credit),
      .cmd_valid_o (cmd_valid),
      .cmd_o       (cmd),
      .rsp_valid_i (rsp_valid),
      .rsp_data_i  (rsp_data)
   );

   bind uart_tx_arbiter apb_uart_assert u_tx_assert (
      .CLK         (CLK),
      .RSTN        (RSTN),
      .credits_i   (credits_q),
      .tx_valid_i  (tx_valid_o),
      .tx_credit_i (tx_credit_i),
      .cmd_valid_i (1'b0)
   );

   bind su_cmd_parser apb_uart_assert u_cmd_assert (
      .CLK         (CLK),
      .RSTN        (RSTN),
      .credits_i   (3'd0),
      .tx_valid_i  (1'b0),
      .tx_credit_i (1'b0),
      .cmd_valid_i (cmd_valid_o)
   );

   initial
   begin
      CLK = 1'b0;
      forever #(CLK_PERIOD / 2) CLK = ~CLK;
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("Timeout: the tests did not finish in time");
      $display("Something failed");
      $finish;
   end

   // phy model returns each byte's credit about 3 cycles later
   always @(posedge CLK)
   begin
      phy_give = 1'b0;
      if (!RSTN)
      begin
         phy_pipe  = '0;
         owed      = 0;
         in_flight = 0;
      end
      else
      begin
         if (tx_valid)
         begin
            tx_seen.push_back(tx_data);
            in_flight++;
         end
         if (tx_credit)
            in_flight--;
         assert (in_flight <= TX_LINK_CREDITS)
            else note_failure("more TX bytes in flight than the link has credits");
         owed     = owed + int'(phy_pipe[2]);
         phy_pipe = {phy_pipe[1:0], tx_valid};
         phy_give = !hold_credits && (owed > 0);   // held credits pile up in owed
         if (phy_give)
            owed--;
      end
      #1;
      tx_credit = phy_give;
   end

   // rx sender credit bookkeeping
   always @(posedge CLK)
   begin
      if (!RSTN)
      begin
         rx_credits   = RX_LINK_CREDITS;
         credit_count = 0;
         rx_sent      = 0;
      end
      else
      begin
         if (rx_valid)
         begin
            rx_credits--;
            rx_sent++;
         end
         if (rx_credit)
         begin
            rx_credits++;
            credit_count++;
         end
         assert (rx_credits <= RX_LINK_CREDITS)
            else note_failure("RX link returned more credits than were spent");
      end
   end

   always @(posedge CLK)
   begin
      if (RSTN && cmd_valid)
         cmd_seen.push_back(cmd);
      if (RSTN)
         assert (!(cmd_valid && cmd_valid_d))
            else note_failure("cmd_valid_o stayed high for more than one cycle");
      cmd_valid_d = RSTN && cmd_valid;
   end

   // remote master, serves one read at a time
   always @(posedge CLK)
   begin
      if (RSTN && cmd_valid && (cmd.op == OP_RD_WORD))
      begin
         rd_addr = cmd.word.ad.addr;
         repeat (2) @(posedge CLK);
         #1;
         rsp_data  = rd_addr ^ RSP_MASK;
         rsp_valid = 1'b1;
         @(posedge CLK);
         #1;
         rsp_valid = 1'b0;
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] random_word();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   function automatic logic [7:0] random_byte(input bit avoid_codes);
      logic [31:0] w;
      logic [7:0]  b;
      do
      begin
         w = random_word();
         b = w[7:0];
      end while (avoid_codes && (b >= SU_CMD_WR_WORD) && (b <= SU_CMD_RSP));
      return b;
   endfunction

   task automatic note_failure(input string msg);
      errors++;
      $display("%s", msg);
   endtask

   task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp)
         else
         begin
            errors++;
            $display("Fail %s: got %0h, expected %0h", what, got, exp);
         end
   endtask

   task automatic apb_write(input logic [2:0] addr, input logic [7:0] data);
      apb_req.addr   = addr;
      apb_req.wdata  = data;
      apb_req.write  = 1'b1;
      apb_req.sel    = 1'b1;
      apb_req.enable = 1'b0;
      @(posedge CLK);
      #1;
      apb_req.enable = 1'b1;   // access phase, write lands at the next edge
      @(posedge CLK);
      #1;
      apb_req = '0;
   endtask

   task automatic apb_read(input logic [2:0] addr, output logic [7:0] data);
      apb_req.addr   = addr;
      apb_req.wdata  = 8'h00;
      apb_req.write  = 1'b0;
      apb_req.sel    = 1'b1;
      apb_req.enable = 1'b0;
      @(posedge CLK);
      #1;
      apb_req.enable = 1'b1;
      #4;
      data = prdata;   // sampled mid access phase
      @(posedge CLK);
      #1;
      apb_req = '0;
   endtask

   task automatic send_rx_byte(input logic [7:0] b);
      int waited;
      waited = 0;
      while ((rx_credits == 0) && (waited < 100))
      begin
         @(posedge CLK);
         #1;
         waited++;
      end
      if (rx_credits == 0)
         note_failure("RX sender never got a credit back");
      else
      begin
         rx_valid = 1'b1;
         rx_data  = b;
         @(posedge CLK);
         #1;
         rx_valid = 1'b0;
      end
   endtask

   task automatic wait_tx_bytes(input int n);
      int waited;
      waited = 0;
      while ((tx_seen.size() < n) && (waited < 500))
      begin
         @(posedge CLK);
         #1;
         waited++;
      end
      if (tx_seen.size() < n)
         note_failure("timed out waiting for bytes on the TX link");
   endtask

   task automatic wait_cmds(input int n);
      int waited;
      waited = 0;
      while ((cmd_seen.size() < n) && (waited < 200))
      begin
         @(posedge CLK);
         #1;
         waited++;
      end
      if (cmd_seen.size() < n)
         note_failure("timed out waiting for a command strobe");
   endtask

   // polls TEMT until the fifo is empty and all credits are home
   task automatic wait_tx_drain();
      logic [7:0] lsr;
      int         polls;
      polls = 0;
      do
      begin
         apb_read(REG_LSR, lsr);
         polls++;
      end while (!lsr[LSR_TEMT_BIT] && (polls < 200));
      if (!lsr[LSR_TEMT_BIT])
         note_failure("TX side never went idle");
   endtask

   task automatic check_tx_stream();
      int i;
      check_eq("tx byte count", tx_seen.size(), tx_expect.size());
      for (i = 0; (i < tx_expect.size()) && (i < tx_seen.size()); i++)
         check_eq($sformatf("tx_data_o byte %0d", i), tx_seen[i], tx_expect[i]);
   endtask

   task automatic run_write_cmd(input logic [7:0] code, input su_op_e op, input int data_len);
      logic [31:0] addr;
      logic [31:0] data;
      logic [7:0]  payload[$];
      logic [63:0] exp_word;
      logic [63:0] got_word;
      int          k;
      addr = random_word();
      data = random_word();
      for (k = 0; k < 4; k++)
         payload.push_back(addr[31-8*k -: 8]);
      for (k = 0; k < data_len; k++)
         payload.push_back(data[31-8*k -: 8]);
      exp_word = '0;   // unfilled low bytes stay zero
      for (k = 0; k < payload.size(); k++)
         exp_word[63-8*k -: 8] = payload[k];
      cmd_seen.delete();
      send_rx_byte(code);
      for (k = 0; k < payload.size(); k++)
         send_rx_byte(payload[k]);
      wait_cmds(1);
      repeat (2) @(posedge CLK);
      #1;
      check_eq("cmd_valid_o pulses", cmd_seen.size(), 1);
      if (cmd_seen.size() > 0)
      begin
         got_word = cmd_seen[0].word;
         check_eq("cmd_o.op", cmd_seen[0].op, op);
         check_eq("cmd_o addr", got_word[63:32], exp_word[63:32]);
         check_eq("cmd_o data", got_word[31:0], exp_word[31:0]);
      end
   endtask

   task automatic test_reset();
      logic [7:0] val;
      check_eq("tx_valid_o", tx_valid, 1'b0);
      check_eq("cmd_valid_o", cmd_valid, 1'b0);
      check_eq("rx_credit_o", rx_credit, 1'b0);
      apb_read(REG_LSR, val);
      check_eq("LSR", val, LSR_RESET);
      apb_read(REG_SCR, val);
      check_eq("SCR su_en", val[SCR_SU_EN_BIT], 1'b1);
   endtask

   task automatic test_tx_path();
      logic [7:0] b;
      logic [7:0] lsr;
      int         i;
      tx_seen.delete();
      tx_expect.delete();
      for (i = 0; i < 20; i++)
      begin
         b = random_byte(1'b1);
         tx_expect.push_back(b);
         apb_write(REG_RBR_THR, b);
      end
      wait_tx_bytes(20);
      wait_tx_drain();
      check_tx_stream();
      apb_read(REG_LSR, lsr);
      check_eq("LSR", lsr, LSR_RESET);
   endtask

   task automatic test_rx_path();
      logic [7:0] sent[$];
      logic [7:0] b;
      logic [7:0] got;
      int         i;
      apb_write(REG_SCR, 8'h00);   // smart uart off
      credit_count = 0;
      for (i = 0; i < RX_FIFO_DEPTH; i++)
      begin
         b = random_byte(1'b0);
         sent.push_back(b);
         send_rx_byte(b);
      end
      for (i = 0; i < RX_FIFO_DEPTH; i++)
      begin
         apb_read(REG_RBR_THR, got);
         check_eq($sformatf("RBR byte %0d", i), got, sent[i]);
      end
      repeat (3) @(posedge CLK);
      #1;
      apb_read(REG_LSR, got);
      check_eq("LSR data ready", got[LSR_DR_BIT], 1'b0);
      check_eq("rx_credit_o pulses", credit_count, RX_FIFO_DEPTH);
      check_eq("rx sender credits", rx_credits, RX_LINK_CREDITS);
      apb_write(REG_SCR, 8'(1 << SCR_SU_EN_BIT));
   endtask

   task automatic test_write_cmds();
      logic [7:0] lsr;
      int         sent_before;
      credit_count = 0;
      sent_before  = rx_sent;
      run_write_cmd(SU_CMD_WR_WORD, OP_WR_WORD, SU_LEN_WR_WORD - 4);
      run_write_cmd(SU_CMD_WR_HALF, OP_WR_HALF, SU_LEN_WR_HALF - 4);
      run_write_cmd(SU_CMD_WR_BYTE, OP_WR_BYTE, SU_LEN_WR_BYTE - 4);
      repeat (3) @(posedge CLK);
      #1;
      apb_read(REG_LSR, lsr);
      check_eq("LSR data ready", lsr[LSR_DR_BIT], 1'b0);   // nothing reached the rx fifo
      check_eq("rx_credit_o pulses", credit_count, rx_sent - sent_before);
      check_eq("rx sender credits", rx_credits, RX_LINK_CREDITS);
   endtask

   task automatic test_read_cmd();
      logic [31:0] addr;
      logic [31:0] exp_rsp;
      logic [63:0] got_word;
      logic [7:0]  thr_byte;
      int          k;
      addr     = random_word();
      exp_rsp  = addr ^ RSP_MASK;
      thr_byte = random_byte(1'b1);
      tx_seen.delete();
      tx_expect.delete();
      cmd_seen.delete();
      send_rx_byte(SU_CMD_RD_WORD);
      for (k = 0; k < SU_LEN_RD_WORD; k++)
         send_rx_byte(addr[31-8*k -: 8]);
      wait_cmds(1);
      if (cmd_seen.size() > 0)
      begin
         got_word = cmd_seen[0].word;
         check_eq("cmd_o.op", cmd_seen[0].op, OP_RD_WORD);
         check_eq("cmd_o addr", got_word[63:32], addr);
      end
      wait_tx_bytes(1);
      apb_write(REG_RBR_THR, thr_byte);   // lands while the response is going out
      tx_expect.push_back(SU_CMD_RSP);
      for (k = 0; k < 4; k++)
         tx_expect.push_back(exp_rsp[31-8*k -: 8]);
      tx_expect.push_back(thr_byte);
      wait_tx_bytes(SU_RSP_LEN + 1);
      wait_tx_drain();
      check_tx_stream();
   endtask

   task automatic test_tx_clear();
      logic [7:0] b;
      logic [7:0] lsr;
      int         k;
      tx_seen.delete();
      tx_expect.delete();
      hold_credits = 1'b1;
      // these use up every credit and leave the dut
      for (k = 0; k < TX_LINK_CREDITS; k++)
      begin
         b = random_byte(1'b1);
         tx_expect.push_back(b);
         apb_write(REG_RBR_THR, b);
      end
      wait_tx_bytes(TX_LINK_CREDITS);
      for (k = 0; k < 3; k++)
         apb_write(REG_RBR_THR, random_byte(1'b1));
      repeat (2) @(posedge CLK);
      #1;
      check_eq("tx bytes without credits", tx_seen.size(), TX_LINK_CREDITS);
      apb_write(REG_FCR, 8'(1 << FCR_TX_CLR_BIT));
      apb_read(REG_LSR, lsr);
      check_eq("LSR THRE after clear", lsr[LSR_THRE_BIT], 1'b1);
      b = random_byte(1'b1);
      tx_expect.push_back(b);
      apb_write(REG_RBR_THR, b);
      hold_credits = 1'b0;
      wait_tx_bytes(TX_LINK_CREDITS + 1);
      wait_tx_drain();
      check_tx_stream();
   endtask

   initial
   begin
      errors       = 0;
      checks       = 0;
      rng_state    = SEED;
      hold_credits = 1'b0;
      RSTN         = 1'b0;
      apb_req      = '0;
      rx_valid     = 1'b0;
      rx_data      = 8'h00;
      tx_credit    = 1'b0;
      rsp_valid    = 1'b0;
      rsp_data     = 32'h0;
      repeat (RESET_CYCLES) @(posedge CLK);
      #1;
      RSTN = 1'b1;

      test_reset();
      test_tx_path();
      test_rx_path();
      test_write_cmds();
      test_read_cmd();
      test_tx_clear();

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verif/apb_uart_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

// bound once into the tx arbiter and once into the parser
// inputs that do not belong to a target are tied off
module apb_uart_assert
   import uart_reg_pkg::*;
(
   input  wire logic       CLK,
   input  wire logic       RSTN,
   input  wire logic [2:0] credits_i,
   input  wire logic       tx_valid_i,
   input  wire logic       tx_credit_i,
   input  wire logic       cmd_valid_i
);

   logic [2:0] in_flight_q;   // bytes on the link not yet credited back

   always_ff @(posedge CLK or negedge RSTN)
   begin
      if (!RSTN)
         in_flight_q <= '0;
      else
         in_flight_q <= in_flight_q + 3'(tx_valid_i) - 3'(tx_credit_i);
   end

   // counter can only refill up to the phy buffer size
   a_credit_limit: assert property (@(posedge CLK) disable iff (!RSTN)
      credits_i <= 3'(TX_LINK_CREDITS))
      else $error("tx credit counter above the link limit");

   a_valid_needs_credit: assert property (@(posedge CLK) disable iff (!RSTN)
      tx_valid_i |-> (in_flight_q < 3'(TX_LINK_CREDITS)))
      else $error("tx byte sent without a credit");

   a_cmd_pulse: assert property (@(posedge CLK) disable iff (!RSTN)
      cmd_valid_i |=> !cmd_valid_i)   // one cycle strobe per command
      else $error("command strobe longer than one cycle");

endmodule

`default_nettype wire

// ==== design/apb_uart_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module apb_uart_top
   import uart_reg_pkg::*, su_proto_pkg::*;
(
   input  logic        CLK,
   input  logic        RSTN,
   input  apb_req_t    apb_req_i,
   output logic [7:0]  prdata_o,
   input  logic        rx_valid_i,
   input  logic [7:0]  rx_data_i,
   output logic        rx_credit_o,
   output logic        tx_valid_o,
   output logic [7:0]  tx_data_o,
   input  logic        tx_credit_i,
   output logic        cmd_valid_o,
   output su_cmd_t     cmd_o,
   input  logic        rsp_valid_i,
   input  logic [31:0] rsp_data_i
);

   logic       rx_push;
   logic       rx_pop;
   logic [7:0] rx_head;
   logic       rx_empty;
   logic       tx_push;
   logic       tx_clr;
   logic       tx_pop;
   logic [7:0] tx_head;
   logic       tx_empty;
   logic       tx_full;
   logic       tx_idle;
   logic       su_en;
   logic       rd_pending;
   logic       rsp_taken;
   logic       su_valid;
   logic [7:0] su_byte;
   logic       su_take;

   // rx side never clears, credits keep it from overflowing
   byte_fifo #(
      .DEPTH (RX_FIFO_DEPTH)
   ) u_rx_fifo (
      .CLK         (CLK),
      .RSTN        (RSTN),
      .clr_i       (1'b0),
      .push_i      (rx_push),
      .push_data_i (rx_data_i),
      .pop_i       (rx_pop),
      .head_o      (rx_head),
      .empty_o     (rx_empty),
      .full_o      (),
      .count_o     ()
   );

   byte_fifo #(
      .DEPTH (TX_FIFO_DEPTH)
   ) u_tx_fifo (
      .CLK         (CLK),
      .RSTN        (RSTN),
      .clr_i       (tx_clr),
      .push_i      (tx_push),
      .push_data_i (apb_req_i.wdata),   // THR data
      .pop_i       (tx_pop),
      .head_o      (tx_head),
      .empty_o     (tx_empty),
      .full_o      (tx_full),
      .count_o     ()
   );

   uart_regs u_regs (
      .CLK        (CLK),
      .RSTN       (RSTN),
      .apb_req_i  (apb_req_i),
      .prdata_o   (prdata_o),
      .rx_head_i  (rx_head),
      .rx_empty_i (rx_empty),
      .rx_pop_o   (rx_pop),
      .tx_push_o  (tx_push),
      .tx_clr_o   (tx_clr),
      .tx_empty_i (tx_empty),
      .tx_full_i  (tx_full),
      .tx_idle_i  (tx_idle),
      .su_en_o    (su_en)
   );

   su_cmd_parser u_parser (
      .CLK          (CLK),
      .RSTN         (RSTN),
      .su_en_i      (su_en),
      .rx_valid_i   (rx_valid_i),
      .rx_data_i    (rx_data_i),
      .fifo_push_o  (rx_push),
      .fifo_pop_i   (rx_pop),
      .rx_credit_o  (rx_credit_o),
      .cmd_valid_o  (cmd_valid_o),
      .cmd_o        (cmd_o),
      .rd_pending_o (rd_pending),
      .rsp_taken_i  (rsp_taken)
   );

   su_rsp_serializer u_serializer (
      .CLK          (CLK),
      .RSTN         (RSTN),
      .rd_pending_i (rd_pending),
      .rsp_valid_i  (rsp_valid_i),
      .rsp_data_i   (rsp_data_i),
      .rsp_taken_o  (rsp_taken),
      .byte_valid_o (su_valid),
      .byte_o       (su_byte),
      .byte_take_i  (su_take)
   );

   uart_tx_arbiter u_arbiter (
      .CLK          (CLK),
      .RSTN         (RSTN),
      .su_valid_i   (su_valid),
      .su_byte_i    (su_byte),
      .su_take_o    (su_take),
      .fifo_head_i  (tx_head),
      .fifo_empty_i (tx_empty),
      .fifo_pop_o   (tx_pop),
      .tx_valid_o   (tx_valid_o),
      .tx_data_o    (tx_data_o),
      .tx_credit_i  (tx_credit_i),
      .tx_idle_o    (tx_idle)
   );

endmodule

`default_nettype wire

// ==== design/uart_tx_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_tx_arbiter
   import uart_reg_pkg::*;
(
   input  logic       CLK,
   input  logic       RSTN,
   input  logic       su_valid_i,
   input  logic [7:0] su_byte_i,
   output logic       su_take_o,
   input  logic [7:0] fifo_head_i,
   input  logic       fifo_empty_i,
   output logic       fifo_pop_o,
   output logic       tx_valid_o,
   output logic [7:0] tx_data_o,
   input  logic       tx_credit_i,
   output logic       tx_idle_o
);

   logic [2:0] credits_q;
   logic       su_started_q;    // response owns the link until its last byte
   logic       use_su;
   logic       send;

   // a waiting response goes once the fifo drains or it has already begun
   assign use_su = su_valid_i && (su_started_q || fifo_empty_i);
   assign send   = (credits_q != 3'd0) && (use_su || !fifo_empty_i);

   assign tx_valid_o = send;
   assign tx_data_o  = use_su ? su_byte_i : fifo_head_i;
   assign su_take_o  = send && use_su;
   assign fifo_pop_o = send && !use_su;
   assign tx_idle_o  = (credits_q == 3'(TX_LINK_CREDITS));

   always_ff @(posedge CLK or negedge RSTN)
   begin
      if (!RSTN)
      begin
         credits_q    <= 3'(TX_LINK_CREDITS);
         su_started_q <= 1'b0;
      end
      else
      begin
         credits_q    <= credits_q - 3'(send) + 3'(tx_credit_i);
         su_started_q <= su_valid_i && (su_started_q || su_take_o);
      end
   end

endmodule

`default_nettype wire

// ==== design/su_rsp_serializer.sv ====
`timescale 1ns/100ps
`default_nettype none

module su_rsp_serializer
   import su_proto_pkg::*;
(
   input  logic        CLK,
   input  logic        RSTN,
   input  logic        rd_pending_i,
   input  logic        rsp_valid_i,
   input  logic [31:0] rsp_data_i,
   output logic        rsp_taken_o,
   output logic        byte_valid_o,
   output logic [7:0]  byte_o,
   input  logic        byte_take_i
);

   logic [2:0]  left_q;    // bytes still to send
   logic [31:0] data_q;
   logic [1:0]  byte_sel;
   logic        accept;

   // stray responses are dropped
   assign accept       = rsp_valid_i && rd_pending_i && (left_q == 3'd0);
   assign rsp_taken_o  = accept;
   assign byte_valid_o = (left_q != 3'd0);

   // left 4..1 picks data byte 3..0
   assign byte_sel = left_q[1:0] - 2'd1;

   always_comb
   begin
      if (left_q == 3'(SU_RSP_LEN))
         byte_o = SU_CMD_RSP;
      else
         byte_o = data_q[8*byte_sel +: 8];
   end

   always_ff @(posedge CLK or negedge RSTN)
   begin
      if (!RSTN)
         left_q <= '0;
      else if (accept)
         left_q <= 3'(SU_RSP_LEN);
      else if (byte_take_i && byte_valid_o)
         left_q <= left_q - 1'b1;
   end

   always_ff @(posedge CLK)
   begin
      if (accept)
         data_q <= rsp_data_i;
   end

endmodule

`default_nettype wire

// ==== design/su_cmd_parser.sv ====
`timescale 1ns/100ps
`default_nettype none

module su_cmd_parser
   import su_proto_pkg::*;
(
   input  logic       CLK,
   input  logic       RSTN,
   input  logic       su_en_i,
   input  logic       rx_valid_i,
   input  logic [7:0] rx_data_i,
   output logic       fifo_push_o,
   input  logic       fifo_pop_i,
   output logic       rx_credit_o,
   output logic       cmd_valid_o,
   output su_cmd_t    cmd_o,
   output logic       rd_pending_o,
   input  logic       rsp_taken_i
);

   logic [3:0] cmd_len;
   su_op_e     cmd_op;
   logic [3:0] pay_cnt_q;      // payload bytes still expected
   logic       in_payload;
   logic       is_cmd;
   logic       absorb;
   logic       last_byte;
   su_op_e     op_q;
   su_word_u   word_q;
   logic [2:0] byte_idx_q;
   logic       cmd_valid_q;
   logic       rd_pending_q;
   logic       absorbed_q;
   logic       popped_q;
   logic       credit_pend_q;

   // code lookup, zero length means not a command
   always_comb
   begin
      cmd_len = 4'd0;
      cmd_op  = OP_WR_WORD;
      case (rx_data_i)
         SU_CMD_WR_WORD:
         begin
            cmd_len = 4'(SU_LEN_WR_WORD);
            cmd_op  = OP_WR_WORD;
         end
         SU_CMD_WR_HALF:
         begin
            cmd_len = 4'(SU_LEN_WR_HALF);
            cmd_op  = OP_WR_HALF;
         end
         SU_CMD_WR_BYTE:
         begin
            cmd_len = 4'(SU_LEN_WR_BYTE);
            cmd_op  = OP_WR_BYTE;
         end
         SU_CMD_RD_WORD:
         begin
            cmd_len = 4'(SU_LEN_RD_WORD);
            cmd_op  = OP_RD_WORD;
         end
         default: ;
      endcase
   end

   assign in_payload  = (pay_cnt_q != 4'd0);
   assign is_cmd      = rx_valid_i && su_en_i && !in_payload && (cmd_len != 4'd0);
   assign absorb      = (rx_valid_i && in_payload) || is_cmd;
   assign last_byte   = rx_valid_i && (pay_cnt_q == 4'd1);
   assign fifo_push_o = rx_valid_i && !absorb;

   assign cmd_valid_o  = cmd_valid_q;
   assign cmd_o.op     = op_q;
   assign cmd_o.word   = word_q;
   assign rd_pending_o = rd_pending_q;

   // fifo credit goes out on time, the parser one slips a cycle on a clash
   assign rx_credit_o = popped_q || absorbed_q || credit_pend_q;

   always_ff @(posedge CLK or negedge RSTN)
   begin
      if (!RSTN)
      begin
         pay_cnt_q     <= '0;
         cmd_valid_q   <= 1'b0;
         rd_pending_q  <= 1'b0;
         absorbed_q    <= 1'b0;
         popped_q      <= 1'b0;
         credit_pend_q <= 1'b0;
      end
      else
      begin
         if (is_cmd)
            pay_cnt_q <= cmd_len;
         else if (rx_valid_i && in_payload)
            pay_cnt_q <= pay_cnt_q - 1'b1;
         cmd_valid_q <= last_byte;
         if (last_byte && (op_q == OP_RD_WORD))
            rd_pending_q <= 1'b1;
         else if (rsp_taken_i)
            rd_pending_q <= 1'b0;
         absorbed_q <= absorb;
         popped_q   <= fifo_pop_i;
         if (popped_q)
            credit_pend_q <= absorbed_q || credit_pend_q;
         else
            credit_pend_q <= absorbed_q && credit_pend_q;   // one of two still owed
      end
   end

   // command word, filled from byte 7 down, addr msb first
   always_ff @(posedge CLK)
   begin
      if (is_cmd)
      begin
         op_q       <= cmd_op;
         word_q     <= '0;
         byte_idx_q <= 3'd7;
      end
      else if (rx_valid_i && in_payload)
      begin
         word_q.bytes[byte_idx_q] <= rx_data_i;
         byte_idx_q               <= byte_idx_q - 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== design/uart_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_regs
   import uart_reg_pkg::*;
(
   input  logic       CLK,
   input  logic       RSTN,
   input  apb_req_t   apb_req_i,
   output logic [7:0] prdata_o,
   input  logic [7:0] rx_head_i,
   input  logic       rx_empty_i,
   output logic       rx_pop_o,
   output logic       tx_push_o,
   output logic       tx_clr_o,
   input  logic       tx_empty_i,
   input  logic       tx_full_i,
   input  logic       tx_idle_i,
   output logic       su_en_o
);

   logic       apb_wr;
   logic       apb_rd;
   logic       tx_clr_q;
   logic [7:0] scr_q;
   logic [7:0] lsr;

   // zero wait states, so the access phase is the only cycle that acts
   assign apb_wr = apb_req_i.sel && apb_req_i.enable && apb_req_i.write;
   assign apb_rd = apb_req_i.sel && apb_req_i.enable && !apb_req_i.write;

   assign tx_push_o = apb_wr && (apb_req_i.addr == REG_RBR_THR) && !tx_full_i;
   assign rx_pop_o  = apb_rd && (apb_req_i.addr == REG_RBR_THR) && !rx_empty_i;

   assign tx_clr_o = tx_clr_q;
   assign su_en_o  = scr_q[SCR_SU_EN_BIT];

   // line status built live from the fifo flags
   always_comb
   begin
      lsr               = 8'h00;
      lsr[LSR_DR_BIT]   = !rx_empty_i;
      lsr[LSR_THRE_BIT] = tx_empty_i;
      lsr[LSR_TEMT_BIT] = tx_empty_i && tx_idle_i;
   end

   always_comb
   begin
      prdata_o = 8'h00;
      if (apb_rd)
      begin
         case (apb_req_i.addr)
            REG_RBR_THR: prdata_o = rx_head_i;
            REG_LSR:     prdata_o = lsr;
            REG_SCR:     prdata_o = scr_q;
            default:     prdata_o = 8'h00;   // FCR is write only
         endcase
      end
   end

   always_ff @(posedge CLK or negedge RSTN)
   begin
      if (!RSTN)
      begin
         tx_clr_q             <= 1'b0;
         scr_q                <= 8'h00;
         scr_q[SCR_SU_EN_BIT] <= 1'b1;
      end
      else
      begin
         // one cycle clear pulse
         tx_clr_q <= apb_wr && (apb_req_i.addr == REG_FCR)
                     && apb_req_i.wdata[FCR_TX_CLR_BIT];
         if (apb_wr && (apb_req_i.addr == REG_SCR))
            scr_q <= apb_req_i.wdata;
      end
   end

endmodule

`default_nettype wire

// ==== design/byte_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module byte_fifo #(
   parameter int DEPTH = 16
) (
   input  logic       CLK,
   input  logic       RSTN,
   input  logic       clr_i,
   input  logic       push_i,
   input  logic [7:0] push_data_i,
   input  logic       pop_i,
   output logic [7:0] head_o,
   output logic       empty_o,
   output logic       full_o,
   output logic [4:0] count_o
);

   localparam int AW = $clog2(DEPTH);

   logic [7:0]    mem [DEPTH];
   logic [AW-1:0] wr_ptr_q;
   logic [AW-1:0] rd_ptr_q;
   logic [4:0]    count_q;
   logic          do_push;
   logic          do_pop;

   assign empty_o = (count_q == 5'd0);
   assign full_o  = (count_q == 5'(DEPTH));
   assign count_o = count_q;
   assign head_o  = mem[rd_ptr_q];   // first-word fall-through

   assign do_push = push_i && !full_o;   // push on full is lost
   assign do_pop  = pop_i && !empty_o;

   always_ff @(posedge CLK)
   begin
      if (do_push)
         mem[wr_ptr_q] <= push_data_i;
   end

   always_ff @(posedge CLK or negedge RSTN)
   begin
      if (!RSTN)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else if (clr_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         if (do_pop)
            rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         count_q <= count_q + 5'(do_push) - 5'(do_pop);
      end
   end

endmodule

`default_nettype wire

// ==== design/su_proto_pkg.sv ====
`default_nettype none

package su_proto_pkg;

   // command codes seen on the rx byte stream
   localparam logic [7:0] SU_CMD_WR_WORD = 8'hA1;
   localparam logic [7:0] SU_CMD_WR_HALF = 8'hA2;
   localparam logic [7:0] SU_CMD_WR_BYTE = 8'hA3;
   localparam logic [7:0] SU_CMD_RD_WORD = 8'hA4;
   localparam logic [7:0] SU_CMD_RSP     = 8'hA5;  // header of a read response

   // payload bytes following each code
   localparam int SU_LEN_WR_WORD = 8;   // addr + 4 data bytes
   localparam int SU_LEN_WR_HALF = 6;   // addr + 2 data bytes
   localparam int SU_LEN_WR_BYTE = 5;   // addr + 1 data byte
   localparam int SU_LEN_RD_WORD = 4;   // addr only

   localparam int SU_RSP_LEN = 5;       // header plus four data bytes

   typedef enum logic [1:0] {
      OP_WR_WORD,
      OP_WR_HALF,
      OP_WR_BYTE,
      OP_RD_WORD
   } su_op_e;

   typedef struct packed {
      logic [31:0] addr;
      logic [31:0] data;
   } su_addr_data_t;

   // filled bytewise by the parser, read as addr/data by the remote master
   typedef union packed {
      logic [7:0][7:0] bytes;
      su_addr_data_t   ad;
   } su_word_u;

   typedef struct packed {
      su_op_e   op;
      su_word_u word;
   } su_cmd_t;

endpackage

`default_nettype wire

// ==== design/uart_reg_pkg.sv ====
`default_nettype none

package uart_reg_pkg;

   // register offsets, RBR and THR share one
   localparam logic [2:0] REG_RBR_THR = 3'd0;
   localparam logic [2:0] REG_FCR     = 3'd2;
   localparam logic [2:0] REG_LSR     = 3'd5;
   localparam logic [2:0] REG_SCR     = 3'd7;

   localparam int FCR_TX_CLR_BIT = 2;

   localparam int LSR_DR_BIT   = 0;    // rx byte waiting
   localparam int LSR_THRE_BIT = 5;    // tx fifo empty
   localparam int LSR_TEMT_BIT = 6;    // tx fifo empty and phy drained
   localparam logic [7:0] LSR_RESET = 8'h60;

   localparam int SCR_SU_EN_BIT = 1;   // smart uart on, set out of reset

   localparam int TX_FIFO_DEPTH = 16;
   localparam int RX_FIFO_DEPTH = 16;

   // the sender may fill the whole rx fifo
   localparam int RX_LINK_CREDITS = RX_FIFO_DEPTH;
   localparam int TX_LINK_CREDITS = 4; // phy buffer slots

   typedef struct packed {
      logic [2:0] addr;
      logic [7:0] wdata;
      logic       write;
      logic       sel;
      logic       enable;
   } apb_req_t;

endpackage

`default_nettype wire
